/* sources.f */
ca_pkg.sv
ca_fifo_if.sv
ca_syncfifo.sv
ca_rx_align_fifo.sv
ca_align_ctrl.sv
ca_top.sv
tb_ca_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_ca_top
FILELIST  := sources.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_ca_top.sv */
// Directed testbench for ca_top with clock, watchdog, compare task and test tasks
module tb_ca_top;
  timeunit 1ns;
  timeprecision 100ps;

  import ca_pkg::*;

  localparam int NCH    = 2;
  localparam int BITS   = 16;
  localparam int AW     = 3;
  localparam int DEPTH  = 1 << AW;
  localparam int PERIOD = 4;                      // ns
  localparam int MK     = MARKER_BIT_POS(BITS);

  // Programmable levels, same for both lanes
  localparam int FULL_LVL   = 8;                  // Fill count
  localparam int PFULL_LVL  = 6;
  localparam int EMPTY_LVL  = 8;                  // Free count
  localparam int PEMPTY_LVL = 3;

  localparam int ACK_LIMIT = 40;                  // Cycles from req to ack
  localparam int BUDGET    = 5 + 20 + 120 + 300 + 80 + 80; // Reset plus tests 1 to 5
  localparam int MARGIN    = 100;

  logic                 com_clk = 1'b0;
  logic                 reset;
  logic                 align_req;
  logic                 align_ack;
  logic                 align_ok;
  logic [NCH-1:0]       lane_valid;
  logic [NCH*BITS-1:0]  lane_din;
  logic                 out_ready;
  logic                 aligned_valid;
  logic [NCH*BITS-1:0]  aligned_dout;
  logic [AW:0]          fifo_full_val;
  logic [AW:0]          fifo_pfull_val;
  logic [AW:0]          fifo_empty_val;
  logic [AW:0]          fifo_pempty_val;
  logic [NCH-1:0]       fifo_full;
  logic [NCH-1:0]       fifo_pfull;
  logic [NCH-1:0]       fifo_empty;
  logic [NCH-1:0]       fifo_pempty;
  logic [NCH-1:0]       lane_overflow;
  ca_state_t            st_mon;                   // Controller state, for the timeout line

  int seed = 32'h8389_ea3b;
  int errors = 0;
  int checks = 0;
  int err_base = 0;
  int pre_left [NCH];                             // Random words before marker, -1 never
  int seq_no [NCH];                               // Next sequence number per lane
  bit req_level = 1'b0;
  bit ready_level = 1'b0;

  ca_top
    #(
      .NUM_CHANNELS     (NCH),
      .BITS_PER_CHANNEL (BITS),
      .AD_WIDTH         (AW)
      )
  i_ca_top
    (
     .com_clk         (com_clk),
     .reset           (reset),
     .align_req       (align_req),
     .align_ack       (align_ack),
     .align_ok        (align_ok),
     .lane_valid      (lane_valid),
     .lane_din        (lane_din),
     .out_ready       (out_ready),
     .aligned_valid   (aligned_valid),
     .aligned_dout    (aligned_dout),
     .fifo_full_val   (fifo_full_val),
     .fifo_pfull_val  (fifo_pfull_val),
     .fifo_empty_val  (fifo_empty_val),
     .fifo_pempty_val (fifo_pempty_val),
     .fifo_full       (fifo_full),
     .fifo_pfull      (fifo_pfull),
     .fifo_empty      (fifo_empty),
     .fifo_pempty     (fifo_pempty),
     .lane_overflow   (lane_overflow)
     );

  assign st_mon = i_ca_top.align_ctrl_i.state;

  always #(PERIOD / 2) com_clk = ~com_clk;        // 4 ns period

  ////////////////////
  // Helpers
  ////////////////////

  // Lane word, marker only on sequence 0
  function automatic logic [BITS-1:0] make_word(input int seq);
    logic [BITS-1:0] w;
    w     = BITS'(seq);
    w[MK] = 1'(seq == 0);
    return w;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("ERROR %s: actual 0x%0h expected 0x%0h at %0t ns", name, actual, expected,
                 $time);
      end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    $display("Test %-12s done with %0d errors", name, errors - err_base);
    err_base = errors;
  endtask

  // One clock: drive on the rising edge, return at the falling edge
  task automatic step_cycle(input bit en);
    logic [NCH*BITS-1:0] din_v;
    logic [BITS-1:0]     w;
    @(posedge com_clk);
    din_v = lane_din;
    for (int i = 0; i < NCH; i++)
      begin
        if (en)
          begin
            if (pre_left[i] != 0)
              begin
                w     = BITS'($random(seed));
                w[MK] = 1'b0;                     // Pre-marker filler
                if (pre_left[i] > 0)
                  pre_left[i]--;
              end
            else
              begin
                w = make_word(seq_no[i]);
                seq_no[i]++;
              end
            din_v[i*BITS +: BITS] = w;
          end
      end
    lane_din   <= din_v;
    lane_valid <= {NCH{en}};                      // Paused lanes keep their skew
    align_req  <= req_level;
    out_ready  <= ready_level;
    @(negedge com_clk);
  endtask

  // Full req/ack cycle, lanes paused while ack is held
  task automatic run_alignment(input int pre0, input int pre1, input int hold,
                               input bit exp_ok);
    int n;
    pre_left[0] = pre0;
    pre_left[1] = pre1;
    seq_no[0]   = 0;
    seq_no[1]   = 0;
    ready_level = 1'b0;
    req_level   = 1'b1;
    n           = 0;
    step_cycle(1'b1);
    compare("align_ack", 32'(align_ack), 32'h0); // req not seen yet
    while (!align_ack && n < ACK_LIMIT)
      begin
        step_cycle(1'b1);
        n++;
      end
    if (!align_ack)
      begin
        report_failure("align_ack never rose after align_req");
        return;
      end
    compare("align_ok", 32'(align_ok), 32'(exp_ok));
    repeat (hold)
      begin
        step_cycle(1'b0);
        compare("align_ack", 32'(align_ack), 32'h1);
      end
    req_level = 1'b0;
    n         = 0;
    while (align_ack && n < 4)
      begin
        step_cycle(1'b0);
        n++;
      end
    if (align_ack)
      report_failure("align_ack stayed high after align_req fell");
  endtask

  // Deskewed words must carry equal sequence numbers from 0
  task automatic check_stream(input int n_words);
    int got;
    int n;
    got         = 0;
    n           = 0;
    ready_level = 1'b1;
    while (got < n_words && n < 4 * n_words)
      begin
        step_cycle(1'b1);
        n++;
        if (aligned_valid && out_ready)
          begin
            for (int i = 0; i < NCH; i++)
              compare($sformatf("aligned_dout lane %0d", i),
                      32'(aligned_dout[i*BITS +: BITS]), 32'(make_word(got)));
            got++;
          end
      end
    if (got < n_words)
      report_failure("aligned stream stalled before all words arrived");
  endtask

  // Level flags from the count model, shift = words presented but not yet pushed
  task automatic check_flags(input int shift);
    logic [NCH-1:0] e_full;
    logic [NCH-1:0] e_pfull;
    logic [NCH-1:0] e_empty;
    logic [NCH-1:0] e_pempty;
    int             cnt;
    for (int i = 0; i < NCH; i++)
      begin
        cnt         = seq_no[i] - shift;
        e_full[i]   = 1'(cnt == FULL_LVL);
        e_pfull[i]  = 1'(cnt == PFULL_LVL);
        e_empty[i]  = 1'(DEPTH - cnt == EMPTY_LVL);
        e_pempty[i] = 1'(DEPTH - cnt == PEMPTY_LVL);
      end
    compare("fifo_full", 32'(fifo_full), 32'(e_full));
    compare("fifo_pfull", 32'(fifo_pfull), 32'(e_pfull));
    compare("fifo_empty", 32'(fifo_empty), 32'(e_empty));
    compare("fifo_pempty", 32'(fifo_pempty), 32'(e_pempty));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    compare("align_ack", 32'(align_ack), 32'h0);
    compare("align_ok", 32'(align_ok), 32'h0);
    compare("aligned_valid", 32'(aligned_valid), 32'h0);
    compare("lane_overflow", 32'(lane_overflow), 32'h0);
    check_flags(0);                               // Empty level equals depth
    end_test("reset");
  endtask

  task automatic test_skew();
    run_alignment(4, 7, 1, 1'b1);                 // Lane 1 marker 3 cycles late
    check_stream(12);
    end_test("skew");
  endtask

  task automatic test_handshake();
    repeat (2)
      begin
        step_cycle(1'b1);
        compare("align_ack", 32'(align_ack), 32'h0);
      end
    run_alignment(6, 3, 5, 1'b1);                 // Long ack hold
    check_stream(6);
    run_alignment(5, 5, 1, 1'b1);                 // Restart from stream
    check_stream(8);
    end_test("handshake");
  endtask

  task automatic test_flags();
    run_alignment(2, 2, 1, 1'b1);                 // Stream with out_ready low
    check_flags(0);
    while (seq_no[0] < DEPTH)
      begin
        step_cycle(1'b1);
        check_flags(1);                           // Word on the bus, not yet counted
        step_cycle(1'b0);
        check_flags(0);
      end
    end_test("flags");
  endtask

  task automatic test_overflow();
    run_alignment(2, -1, 1, 1'b0);                // Lane 1 never marks
    compare("lane0 words past depth", 32'(seq_no[0] > DEPTH), 32'h1);
    compare("lane_overflow", 32'(lane_overflow), 32'h1);
    end_test("overflow");
  endtask

  ////////////////////
  // Run
  ////////////////////

  initial
    begin
      reset           = 1'b1;
      align_req       = 1'b0;
      out_ready       = 1'b0;
      lane_valid      = '0;
      lane_din        = '0;
      fifo_full_val   = (AW+1)'(FULL_LVL);
      fifo_pfull_val  = (AW+1)'(PFULL_LVL);
      fifo_empty_val  = (AW+1)'(EMPTY_LVL);
      fifo_pempty_val = (AW+1)'(PEMPTY_LVL);
      pre_left[0]     = 0;
      pre_left[1]     = 0;
      seq_no[0]       = 0;
      seq_no[1]       = 0;
      repeat (5) @(posedge com_clk);              // Reset for 5 cycles
      reset <= 1'b0;
      @(negedge com_clk);
      test_reset();
      test_skew();
      test_handshake();
      test_flags();
      test_overflow();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
        $display("ALL CHECKS PASSED");
      else
        $display("CHECKS FAILED");
      $finish;
    end

  // Watchdog
  initial
    begin
      #((BUDGET + MARGIN) * PERIOD);
      $display("Timeout: run exceeded its cycle budget, controller in %s", st_mon.name());
      $display("CHECKS FAILED");
      $finish;
    end

endmodule

/* ca_top.sv */
// Channel alignment top level with lane FIFOs and alignment controller
module ca_top
  #(
    parameter int NUM_CHANNELS     = ca_pkg::DEF_NUM_CHANNELS,
    parameter int BITS_PER_CHANNEL = ca_pkg::DEF_BITS_PER_CHANNEL,
    parameter int AD_WIDTH         = ca_pkg::DEF_AD_WIDTH
    )
  (
   input  logic                                     com_clk,
   input  logic                                     reset,

   // Host handshake
   input  logic                                     align_req,
   output logic                                     align_ack,
   output logic                                     align_ok,

   // Lane inputs
   input  logic [NUM_CHANNELS-1:0]                  lane_valid,
   input  logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] lane_din,

   // Deskewed stream
   input  logic                                     out_ready,
   output logic                                     aligned_valid,
   output logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] aligned_dout,

   // Levels, shared by all lanes
   input  logic [AD_WIDTH:0]                        fifo_full_val,
   input  logic [AD_WIDTH:0]                        fifo_pfull_val,
   input  logic [AD_WIDTH:0]                        fifo_empty_val,
   input  logic [AD_WIDTH:0]                        fifo_pempty_val,

   // Per-lane status
   output logic [NUM_CHANNELS-1:0]                  fifo_full,
   output logic [NUM_CHANNELS-1:0]                  fifo_pfull,
   output logic [NUM_CHANNELS-1:0]                  fifo_empty,
   output logic [NUM_CHANNELS-1:0]                  fifo_pempty,
   output logic [NUM_CHANNELS-1:0]                  lane_overflow
   );

  // One bundle per lane
  ca_fifo_if #(.BITS_PER_CHANNEL(BITS_PER_CHANNEL), .AD_WIDTH(AD_WIDTH)) lane_if [NUM_CHANNELS] ();

  ////////////////////
  // Lanes
  ////////////////////

  genvar g;
  for (g = 0; g < NUM_CHANNELS; g++)
    begin : g_lane
      ca_rx_align_fifo
        #(
          .BITS_PER_CHANNEL (BITS_PER_CHANNEL),
          .AD_WIDTH         (AD_WIDTH)
          )
      rx_align_fifo_i
        (
         .com_clk         (com_clk),
         .reset           (reset),
         .rx_din          (lane_din[g*BITS_PER_CHANNEL +: BITS_PER_CHANNEL]),
         .fifo_full_val   (fifo_full_val),
         .fifo_pfull_val  (fifo_pfull_val),
         .fifo_empty_val  (fifo_empty_val),
         .fifo_pempty_val (fifo_pempty_val),
         .fifo_port       (lane_if[g])
         );

      assign aligned_dout[g*BITS_PER_CHANNEL +: BITS_PER_CHANNEL] = lane_if[g].dout; // Lane 0 low
      assign fifo_full[g]   = lane_if[g].fifo_full;
      assign fifo_pfull[g]  = lane_if[g].fifo_pfull;
      assign fifo_empty[g]  = lane_if[g].fifo_empty;
      assign fifo_pempty[g] = lane_if[g].fifo_pempty;
    end

  ////////////////////
  // Control
  ////////////////////

  ca_align_ctrl
    #(
      .NUM_CHANNELS     (NUM_CHANNELS),
      .BITS_PER_CHANNEL (BITS_PER_CHANNEL)
      )
  align_ctrl_i
    (
     .com_clk       (com_clk),
     .reset         (reset),
     .align_req     (align_req),
     .out_ready     (out_ready),
     .lane_valid    (lane_valid),
     .lane_din      (lane_din),     // Marker bits only
     .align_ack     (align_ack),
     .align_ok      (align_ok),
     .aligned_valid (aligned_valid),
     .lane_overflow (lane_overflow),
     .lanes         (lane_if)
     );

endmodule

/* ca_align_ctrl.sv */
// Alignment FSM with marker hunt, head check, req/ack handshake and lockstep pop
module ca_align_ctrl
  #(
    parameter int NUM_CHANNELS     = 2,
    parameter int BITS_PER_CHANNEL = 16
    )
  (
   input  logic                                     com_clk,
   input  logic                                     reset,
   input  logic                                     align_req,
   input  logic                                     out_ready,
   input  logic [NUM_CHANNELS-1:0]                  lane_valid,
   input  logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] lane_din,

   output logic                                     align_ack,
   output logic                                     align_ok,
   output logic                                     aligned_valid,
   output logic [NUM_CHANNELS-1:0]                  lane_overflow,

   ca_fifo_if.ctrl                                  lanes [NUM_CHANNELS]
   );

  import ca_pkg::*;

  localparam int MK = MARKER_BIT_POS(BITS_PER_CHANNEL);

  ca_state_t               state;
  ca_state_t               state_nxt;
  logic                    ok_q;        // Result of last check
  logic [NUM_CHANNELS-1:0] seen;        // Marker already taken
  logic [NUM_CHANNELS-1:0] in_marker;   // Marker on incoming word
  logic [NUM_CHANNELS-1:0] head_marker; // Marker on FIFO head
  logic [NUM_CHANNELS-1:0] lane_empty;
  logic [NUM_CHANNELS-1:0] lane_filled;
  logic [NUM_CHANNELS-1:0] ovf;         // Overflow pulses
  logic [NUM_CHANNELS-1:0] push;
  logic [NUM_CHANNELS-1:0] pop;
  logic                    clear;       // Flush lanes
  logic                    hunting;
  logic                    feeding;     // States that accept lane words
  logic                    hunt_ovf;
  logic                    all_filled;
  logic                    markers_ok;

  ////////////////////
  // Lane fan-out
  ////////////////////

  genvar g;
  for (g = 0; g < NUM_CHANNELS; g++)
    begin : g_lane
      assign in_marker[g]   = lane_din[g*BITS_PER_CHANNEL + MK];
      assign head_marker[g] = lanes[g].dout[MK];
      assign lane_empty[g]  = lanes[g].empty;
      assign lane_filled[g] = lanes[g].numfilled != '0;
      assign ovf[g]         = lanes[g].overflow_pulse;

      assign lanes[g].push       = push[g];
      assign lanes[g].pop        = pop[g];
      assign lanes[g].soft_reset = clear;  // Same clear for every lane
    end

  // State decodes
  assign clear   = state == st_clear;
  assign hunting = state == st_hunt;
  assign feeding = state inside {st_hunt, st_check, st_ack, st_stream};

  assign hunt_ovf   = hunting & (|ovf);     // Skew deeper than the FIFO
  assign all_filled = &lane_filled;
  assign markers_ok = &head_marker;         // Every head is a marker

  ////////////////////
  // Push / pop
  ////////////////////

  always_comb
    begin
      for (int i = 0; i < NUM_CHANNELS; i++)
        push[i] = feeding & lane_valid[i] & (seen[i] | (hunting & in_marker[i]));
    end

  assign aligned_valid = (state == st_stream) & ~(|lane_empty);
  assign pop           = {NUM_CHANNELS{aligned_valid & out_ready}}; // Lockstep

  // Host handshake
  assign align_ack = state == st_ack;
  assign align_ok  = align_ack & ok_q;  // Only meaningful with ack

  ////////////////////
  // FSM
  ////////////////////

  always_comb
    begin
      state_nxt = state;
      case (state)
        st_idle:
          if (align_req)
            state_nxt = st_clear;
        st_clear:
          state_nxt = st_hunt;                  // Single cycle flush
        st_hunt:
          if (hunt_ovf)
            state_nxt = st_ack;                 // Fail
          else if (all_filled)
            state_nxt = st_check;
        st_check:
          state_nxt = st_ack;
        st_ack:
          if (!align_req)
            state_nxt = ok_q ? st_stream : st_idle;
        st_stream:
          if (align_req)
            state_nxt = st_clear;               // Realign on new req
        default:
          state_nxt = st_idle;
      endcase
    end

  always_ff @(posedge com_clk)
    begin
      if (reset)
        state <= st_idle;
      else
        state <= state_nxt;
    end

  // Result, seen flags and sticky overflow
  always_ff @(posedge com_clk)
    begin
      if (reset)
        begin
          ok_q          <= 1'b0;
          seen          <= '0;
          lane_overflow <= '0;
        end
      else if (clear)
        begin
          ok_q          <= 1'b0;
          seen          <= '0;
          lane_overflow <= '0;
        end
      else
        begin
          if (state == st_check)
            ok_q <= markers_ok;
          if (hunting)
            seen <= seen | (lane_valid & in_marker);  // First marker opens lane
          lane_overflow <= lane_overflow | ovf;       // Held until next clear
        end
    end

endmodule

/* ca_rx_align_fifo.sv */
// Per-lane alignment FIFO with programmable full/pfull/empty/pempty flags
module ca_rx_align_fifo
  #(
    parameter int BITS_PER_CHANNEL = 16,
    parameter int AD_WIDTH         = 3
    )
  (
   input  logic                        com_clk,
   input  logic                        reset,

   input  logic [BITS_PER_CHANNEL-1:0] rx_din,

   input  logic [AD_WIDTH:0]           fifo_full_val,
   input  logic [AD_WIDTH:0]           fifo_pfull_val,
   input  logic [AD_WIDTH:0]           fifo_empty_val,
   input  logic [AD_WIDTH:0]           fifo_pempty_val,

   ca_fifo_if.fifo                     fifo_port
   );

  logic [AD_WIDTH:0] numempty; // Free slots, for the empty side flags

  // Lane storage, controls straight from the interface
  ca_syncfifo
    #(
      .BITS_PER_CHANNEL (BITS_PER_CHANNEL),
      .AD_WIDTH         (AD_WIDTH)
      )
  syncfifo_i
    (
     .com_clk         (com_clk),
     .reset           (reset),
     .soft_reset      (fifo_port.soft_reset),
     .write_push      (fifo_port.push),
     .read_pop        (fifo_port.pop),
     .wrdata          (rx_din),
     .rddata          (fifo_port.dout),
     .numfilled       (fifo_port.numfilled),
     .numempty        (numempty),
     .full            (),                         // Covered by level flag
     .empty           (fifo_port.empty),
     .overflow_pulse  (fifo_port.overflow_pulse),
     .underflow_pulse ()                          // Pops are gated on empty
     );

  ////////////////////
  // Level flags
  ////////////////////

  always_comb
    begin
      fifo_port.fifo_full   = fifo_port.numfilled == fifo_full_val;   // Fill side
      fifo_port.fifo_pfull  = fifo_port.numfilled == fifo_pfull_val;
      fifo_port.fifo_empty  = numempty == fifo_empty_val;             // Free side
      fifo_port.fifo_pempty = numempty == fifo_pempty_val;
    end

endmodule

/* ca_syncfifo.sv */
// Single-clock show-ahead FIFO with fill/free counts and error pulses
module ca_syncfifo
  #(
    parameter int BITS_PER_CHANNEL = 16,
    parameter int AD_WIDTH         = 3
    )
  (
   input  logic                        com_clk,
   input  logic                        reset,
   input  logic                        soft_reset,
   input  logic                        write_push,
   input  logic                        read_pop,
   input  logic [BITS_PER_CHANNEL-1:0] wrdata,

   output logic [BITS_PER_CHANNEL-1:0] rddata,
   output logic [AD_WIDTH:0]           numfilled,
   output logic [AD_WIDTH:0]           numempty,
   output logic                        full,
   output logic                        empty,
   output logic                        overflow_pulse,
   output logic                        underflow_pulse
   );

  localparam int DEPTH = 1 << AD_WIDTH;

  // Depth as a count value, MSB only
  localparam logic [AD_WIDTH:0] DEPTH_CNT = {1'b1, {AD_WIDTH{1'b0}}};

  logic [BITS_PER_CHANNEL-1:0] mem [DEPTH]; // Storage
  logic [AD_WIDTH:0]           wr_ptr;      // Wrap bit on top
  logic [AD_WIDTH:0]           rd_ptr;
  logic                        do_push;     // Accepted write
  logic                        do_pop;      // Accepted read

  ////////////////////
  // Status
  ////////////////////

  assign empty     = wr_ptr == rd_ptr;
  assign full      = (wr_ptr ^ rd_ptr) == DEPTH_CNT; // Same slot, other lap
  assign numfilled = wr_ptr - rd_ptr;
  assign numempty  = DEPTH_CNT - numfilled;

  assign do_push = write_push & ~full;  // Drop when full
  assign do_pop  = read_pop & ~empty;   // Ignore when empty

  // Head word always visible
  assign rddata = mem[rd_ptr[AD_WIDTH-1:0]];

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge com_clk)
    begin
      if (do_push)
        mem[wr_ptr[AD_WIDTH-1:0]] <= wrdata;
    end

  // Pointers and error pulses
  always_ff @(posedge com_clk)
    begin
      if (reset || soft_reset)
        begin
          wr_ptr          <= '0;
          rd_ptr          <= '0;
          overflow_pulse  <= 1'b0;
          underflow_pulse <= 1'b0;
        end
      else
        begin
          if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
          if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
          overflow_pulse  <= write_push & full;  // One cycle per lost word
          underflow_pulse <= read_pop & empty;
        end
    end

endmodule

/* ca_fifo_if.sv */
// Per-lane FIFO interface with FIFO side and control side modports
interface ca_fifo_if
  #(
    parameter int BITS_PER_CHANNEL = 16,
    parameter int AD_WIDTH         = 3
    );

  ////////////////////
  // Control to FIFO
  ////////////////////

  logic                        push;       // Write lane word
  logic                        pop;        // Advance head
  logic                        soft_reset; // Empty the FIFO

  ////////////////////
  // FIFO to control
  ////////////////////

  logic [BITS_PER_CHANNEL-1:0] dout;           // Show-ahead head word
  logic                        empty;
  logic [AD_WIDTH:0]           numfilled;      // Words held
  logic                        overflow_pulse; // Push dropped

  // Programmable level flags, read at the top level
  logic                        fifo_full;
  logic                        fifo_pfull;
  logic                        fifo_empty;
  logic                        fifo_pempty;

  modport fifo
    (
     input  push, pop, soft_reset,
     output dout, empty, numfilled, overflow_pulse,
     output fifo_full, fifo_pfull, fifo_empty, fifo_pempty
     );

  modport ctrl
    (
     output push, pop, soft_reset,
     input  dout, empty, numfilled, overflow_pulse
     );

endinterface

/* ca_pkg.sv */
// Lane word and count types, marker bit position, alignment state enum
package ca_pkg;

  ////////////////////
  // Default build
  ////////////////////

  localparam int DEF_NUM_CHANNELS     = 2;  // Lanes
  localparam int DEF_BITS_PER_CHANNEL = 16; // Word incl. marker
  localparam int DEF_AD_WIDTH         = 3;  // Depth 8

  // Lane word and FIFO count at the default width
  typedef logic [DEF_BITS_PER_CHANNEL-1:0] lane_word_t;
  typedef logic [DEF_AD_WIDTH:0]           lane_count_t; // One extra bit for a full FIFO

  // Marker rides in the top bit of every lane word
  function automatic int MARKER_BIT_POS(input int width);
    return width - 1;
  endfunction

  ////////////////////
  // Control states
  ////////////////////

  localparam int NUM_CA_STATES = 6;

  typedef enum logic [$clog2(NUM_CA_STATES)-1:0] {
    st_idle,   // Waiting for req
    st_clear,  // Flush all lanes
    st_hunt,   // Wait for markers
    st_check,  // Compare heads
    st_ack,    // Hold ack with result
    st_stream  // Deskewed output
  } ca_state_t;

endpackage
